// File: rtl/game_rom_params.svh
// ####################
// one 4096 word memory holds all three regions
// only the tile length depends on the game byte
// ####################
`ifndef GAME_ROM_PARAMS_SVH
`define GAME_ROM_PARAMS_SVH

`define GR_MEM_AW        12        // word address bits, 4096 words
`define GR_DL_AW         14        // download byte address bits

// region lengths in bytes
`define GR_CPU_LEN       2048
`define GR_TILE_LEN_DEF  2048      // game 0
`define GR_TILE_LEN_ALT  4096      // any other game
`define GR_PCM_LEN       2048

// word offsets in memory
`define GR_CPU_OFFS      12'h000
`define GR_TILE_OFFS     12'h400
`define GR_PCM_OFFS      12'hC00

`endif

// File: rtl/game_rom_pkg.sv
// ####################
// widths come from the params header
// ####################
`include "game_rom_params.svh"

package game_rom_pkg;

	typedef logic [`GR_MEM_AW-1:0] mem_addr_t;  // memory word address
	typedef logic [15:0]           mem_word_t;
	typedef logic [1:0]            byte_strb_t; // bit 1 is the high byte
	typedef logic [`GR_DL_AW-1:0]  dl_addr_t;   // download byte address
	typedef logic [7:0]            game_id_t;

	// where a download byte lands
	typedef enum logic [1:0] {
		REG_NONE,
		REG_CPU,
		REG_TILE,
		REG_PCM
	} region_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_SETUP,
		ARB_ACCESS
	} arb_state_e;

	typedef enum logic [1:0] {
		SLOT_IDLE,
		SLOT_REQ,
		SLOT_WAIT   // second word of a 32 bit read
	} slot_state_e;

endpackage

// File: rtl/rom_loader.sv
// ####################
// host must leave 5 idle cycles between bytes
// bytes are taken only while downloading is high
// ####################
`timescale 1ns/1ps
`include "game_rom_params.svh"

module rom_loader (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       ioctl_wr,
	input  game_rom_pkg::dl_addr_t     ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic                       downloading,
	output logic                       dwnld_busy,
	output game_rom_pkg::game_id_t     game,
	output logic                       wr_req,
	output game_rom_pkg::mem_addr_t    wr_addr,
	output game_rom_pkg::mem_word_t    wr_data,
	output game_rom_pkg::byte_strb_t   wr_strb,
	input  logic                       wr_done
);
	localparam game_rom_pkg::dl_addr_t CPU_BASE = 1; // byte 0 is the game number

	game_rom_pkg::dl_addr_t  tile_len;
	game_rom_pkg::dl_addr_t  tile_base;
	game_rom_pkg::dl_addr_t  pcm_base;
	game_rom_pkg::dl_addr_t  rom_end;
	game_rom_pkg::dl_addr_t  rel;       // byte offset inside the region
	game_rom_pkg::mem_addr_t reg_offs;
	game_rom_pkg::region_e   region;
	logic                    take;

	// region bases follow the game byte
	assign tile_len  = (game == '0) ? game_rom_pkg::dl_addr_t'(`GR_TILE_LEN_DEF) :
		game_rom_pkg::dl_addr_t'(`GR_TILE_LEN_ALT);
	assign tile_base = CPU_BASE + game_rom_pkg::dl_addr_t'(`GR_CPU_LEN);
	assign pcm_base  = tile_base + tile_len;
	assign rom_end   = pcm_base + game_rom_pkg::dl_addr_t'(`GR_PCM_LEN);

	always_comb begin
		region   = game_rom_pkg::REG_NONE;
		rel      = '0;
		reg_offs = `GR_CPU_OFFS;
		if (ioctl_addr >= CPU_BASE && ioctl_addr < tile_base) begin
			region   = game_rom_pkg::REG_CPU;
			rel      = ioctl_addr - CPU_BASE;
			reg_offs = `GR_CPU_OFFS;
		end else if (ioctl_addr >= tile_base && ioctl_addr < pcm_base) begin
			region   = game_rom_pkg::REG_TILE;
			rel      = ioctl_addr - tile_base;
			reg_offs = `GR_TILE_OFFS;
		end else if (ioctl_addr >= pcm_base && ioctl_addr < rom_end) begin
			region   = game_rom_pkg::REG_PCM;
			rel      = ioctl_addr - pcm_base;
			reg_offs = `GR_PCM_OFFS;
		end
	end

	assign take = ioctl_wr && downloading && (region != game_rom_pkg::REG_NONE);
	assign dwnld_busy = downloading || wr_req;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			game   <= '0;
			wr_req <= 1'b0;
		end else begin
			if (wr_done)
				wr_req <= 1'b0;
			// a new byte on the done edge wins
			if (ioctl_wr && downloading && ioctl_addr == '0)
				game <= ioctl_dout;
			if (take)
				wr_req <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			wr_addr <= reg_offs + game_rom_pkg::mem_addr_t'(rel[`GR_DL_AW-1:1]);
			wr_data <= {2{ioctl_dout}};
			wr_strb <= rel[0] ? 2'b01 : 2'b10; // even offset is the high byte
		end
	end

endmodule

// File: rtl/rom_slot.sv
// ####################
// client holds cs and addr until ok
// cache is dropped when a download starts
// ####################
`timescale 1ns/1ps
`include "game_rom_params.svh"

module rom_slot #(
	parameter int DW = 16,
	localparam int AW = (DW == 32) ? `GR_MEM_AW - 1 :
		(DW == 8) ? `GR_MEM_AW + 1 : `GR_MEM_AW
) (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    downloading,
	input  logic                    cs,
	input  logic [AW-1:0]           addr,
	output logic                    ok,
	output logic [DW-1:0]           dout,
	output logic                    rd_req,
	output game_rom_pkg::mem_addr_t rd_addr,
	input  logic                    rd_done,
	input  game_rom_pkg::mem_word_t rd_data
);
	// region picked from the port width
	localparam game_rom_pkg::mem_addr_t OFFS = (DW == 32) ? `GR_TILE_OFFS :
		(DW == 8) ? `GR_PCM_OFFS : `GR_CPU_OFFS;

	game_rom_pkg::slot_state_e state;
	game_rom_pkg::mem_addr_t   word_off;
	logic [AW-1:0]             tag;
	logic [DW-1:0]             data;
	logic [DW-1:0]             fill_data;
	logic                      valid;
	logic                      ok_r;
	logic                      dl_q;
	logic                      hit;
	logic                      last_done;

	assign hit       = valid && (addr == tag);
	assign last_done = rd_done && (DW != 32 || state == game_rom_pkg::SLOT_WAIT);

	// first request goes out in the cs cycle itself
	assign rd_req  = (state != game_rom_pkg::SLOT_IDLE) || (cs && !hit);
	assign rd_addr = OFFS + word_off;

	assign ok   = ok_r && cs && hit;
	assign dout = data;

	generate
		if (DW == 32) begin : g_w32
			game_rom_pkg::mem_word_t hi_r;  // first word is the high half

			always_ff @(posedge CLK) begin
				if (rd_done && state == game_rom_pkg::SLOT_REQ)
					hi_r <= rd_data;
			end
			assign word_off  = {addr, state == game_rom_pkg::SLOT_WAIT};
			assign fill_data = {hi_r, rd_data};
		end else if (DW == 8) begin : g_w8
			assign word_off  = game_rom_pkg::mem_addr_t'(addr[AW-1:1]);
			assign fill_data = addr[0] ? rd_data[7:0] : rd_data[15:8];
		end else begin : g_w16
			assign word_off  = addr;
			assign fill_data = rd_data;
		end
	endgenerate

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= game_rom_pkg::SLOT_IDLE;
			valid <= 1'b0;
			ok_r  <= 1'b0;
			dl_q  <= 1'b0;
		end else begin
			dl_q <= downloading;
			ok_r <= cs && hit;
			case (state)
				game_rom_pkg::SLOT_IDLE:
					if (cs && !hit)
						state <= game_rom_pkg::SLOT_REQ;
				game_rom_pkg::SLOT_REQ:
					if (rd_done)
						state <= (DW == 32) ? game_rom_pkg::SLOT_WAIT : game_rom_pkg::SLOT_IDLE;
				game_rom_pkg::SLOT_WAIT:
					if (rd_done)
						state <= game_rom_pkg::SLOT_IDLE;
				default: state <= game_rom_pkg::SLOT_IDLE;
			endcase
			if (last_done) begin
				valid <= 1'b1;
				ok_r  <= 1'b1;  // fill answers right away
			end
			if (downloading && !dl_q)
				valid <= 1'b0;  // new image coming
		end
	end

	always_ff @(posedge CLK) begin
		if (last_done) begin
			tag  <= addr;
			data <= fill_data;
		end
	end

endmodule

// File: rtl/rom_arbiter.sv
// ####################
// loader always wins, slots rotate
// one APB transfer at a time, 3 cycles each
// ####################
`timescale 1ns/1ps

module rom_arbiter (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  logic                     wr_req,
	input  game_rom_pkg::mem_addr_t  wr_addr,
	input  game_rom_pkg::mem_word_t  wr_data,
	input  game_rom_pkg::byte_strb_t wr_strb,
	output logic                     wr_done,
	input  logic                     cpu_rd_req,
	input  game_rom_pkg::mem_addr_t  cpu_rd_addr,
	output logic                     cpu_rd_done,
	input  logic                     gfx_rd_req,
	input  game_rom_pkg::mem_addr_t  gfx_rd_addr,
	output logic                     gfx_rd_done,
	input  logic                     pcm_rd_req,
	input  game_rom_pkg::mem_addr_t  pcm_rd_addr,
	output logic                     pcm_rd_done,
	output game_rom_pkg::mem_word_t  rd_data,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output game_rom_pkg::mem_addr_t  paddr,
	output game_rom_pkg::mem_word_t  pwdata,
	output game_rom_pkg::byte_strb_t pstrb,
	input  game_rom_pkg::mem_word_t  prdata,
	input  logic                     pready
);
	game_rom_pkg::arb_state_e state;
	game_rom_pkg::mem_addr_t  nxt_addr;
	game_rom_pkg::byte_strb_t nxt_strb;
	logic [3:0]               gnt_r;    // bit 3 loader, then pcm gfx cpu
	logic [3:0]               nxt_gnt;
	logic [1:0]               last_r;   // last slot granted
	logic [2:0]               rd_req;
	logic [2:0]               cand;
	logic                     ld_cand;
	logic                     xfer_done;
	logic                     launch;

	assign rd_req    = {pcm_rd_req, gfx_rd_req, cpu_rd_req};
	assign xfer_done = (state == game_rom_pkg::ARB_ACCESS) && pready;

	// the finishing client still shows its old request, skip it
	assign cand    = rd_req & ~(xfer_done ? gnt_r[2:0] : 3'b000);
	assign ld_cand = wr_req && !(xfer_done && gnt_r[3]);

	always_comb begin
		int k;
		k       = 0;
		nxt_gnt = '0;
		if (ld_cand) begin
			nxt_gnt[3] = 1'b1;
		end else begin
			for (int i = 1; i <= 3; i++) begin
				k = (int'(last_r) + i) % 3;
				if (nxt_gnt[2:0] == 3'b000 && cand[k])
					nxt_gnt[k] = 1'b1;
			end
		end
	end

	always_comb begin
		nxt_addr = cpu_rd_addr;
		nxt_strb = '0;          // no strobes on reads
		if (nxt_gnt[3]) begin
			nxt_addr = wr_addr;
			nxt_strb = wr_strb;
		end else if (nxt_gnt[1]) begin
			nxt_addr = gfx_rd_addr;
		end else if (nxt_gnt[2]) begin
			nxt_addr = pcm_rd_addr;
		end
	end

	// start from idle or chain straight off a finishing transfer
	assign launch = (state == game_rom_pkg::ARB_IDLE || xfer_done) && (nxt_gnt != '0);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state  <= game_rom_pkg::ARB_IDLE;
			gnt_r  <= '0;
			last_r <= 2'd2;     // cpu goes first
			pwrite <= 1'b0;
			pstrb  <= '0;
		end else begin
			case (state)
				game_rom_pkg::ARB_IDLE:
					if (launch)
						state <= game_rom_pkg::ARB_SETUP;
				game_rom_pkg::ARB_SETUP:
					state <= game_rom_pkg::ARB_ACCESS;
				game_rom_pkg::ARB_ACCESS:
					if (pready)
						state <= launch ? game_rom_pkg::ARB_SETUP : game_rom_pkg::ARB_IDLE;
				default: state <= game_rom_pkg::ARB_IDLE;
			endcase
			if (launch) begin
				gnt_r  <= nxt_gnt;
				pwrite <= nxt_gnt[3];
				pstrb  <= nxt_strb;
				if (!nxt_gnt[3])
					last_r <= nxt_gnt[1] ? 2'd1 : (nxt_gnt[2] ? 2'd2 : 2'd0);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (launch) begin
			paddr  <= nxt_addr;
			pwdata <= wr_data;
		end
	end

	assign psel    = (state != game_rom_pkg::ARB_IDLE);
	assign penable = (state == game_rom_pkg::ARB_ACCESS);

	assign wr_done     = xfer_done && gnt_r[3];
	assign cpu_rd_done = xfer_done && gnt_r[0];
	assign gfx_rd_done = xfer_done && gnt_r[1];
	assign pcm_rd_done = xfer_done && gnt_r[2];
	assign rd_data     = prdata;  // valid with the done pulse

endmodule

// File: rtl/rom_store.sv
// ####################
// pready on the second access cycle
// contents are undefined until written
// ####################
`timescale 1ns/1ps
`include "game_rom_params.svh"

module rom_store (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  game_rom_pkg::mem_addr_t  paddr,
	input  game_rom_pkg::mem_word_t  pwdata,
	input  game_rom_pkg::byte_strb_t pstrb,
	output game_rom_pkg::mem_word_t  prdata,
	output logic                     pready
);
	game_rom_pkg::mem_word_t mem [0:(1 << `GR_MEM_AW) - 1];

	logic wait_cyc;
	logic last_cyc;

	assign wait_cyc = psel && penable && !pready;  // first access cycle
	assign last_cyc = psel && penable && pready;

	// one wait state
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			pready <= 1'b0;
		else
			pready <= wait_cyc;
	end

	always_ff @(posedge CLK) begin
		if (wait_cyc)
			prdata <= mem[paddr];
		if (last_cyc && pwrite) begin
			if (pstrb[1])
				mem[paddr][15:8] <= pwdata[15:8];
			if (pstrb[0])
				mem[paddr][7:0] <= pwdata[7:0];
		end
	end

endmodule

// File: rtl/game_rom_top.sv
// ####################
// cpu 16 bit, gfx 32 bit, pcm 8 bit read ports
// all share one APB memory
// ####################
`timescale 1ns/1ps
`include "game_rom_params.svh"

module game_rom_top (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   ioctl_wr,
	input  game_rom_pkg::dl_addr_t ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	input  logic                   downloading,
	output logic                   dwnld_busy,
	output game_rom_pkg::game_id_t game,
	input  logic                   cpu_cs,
	input  logic [`GR_MEM_AW-1:0]  cpu_addr,   // word address
	output logic                   cpu_ok,
	output logic [15:0]            cpu_dout,
	input  logic                   gfx_cs,
	input  logic [`GR_MEM_AW-2:0]  gfx_addr,   // 32 bit address
	output logic                   gfx_ok,
	output logic [31:0]            gfx_dout,
	input  logic                   pcm_cs,
	input  logic [`GR_MEM_AW:0]    pcm_addr,   // byte address
	output logic                   pcm_ok,
	output logic [7:0]             pcm_dout
);
	logic                     wr_req;
	game_rom_pkg::mem_addr_t  wr_addr;
	game_rom_pkg::mem_word_t  wr_data;
	game_rom_pkg::byte_strb_t wr_strb;
	logic                     wr_done;
	logic                     cpu_rd_req, gfx_rd_req, pcm_rd_req;
	game_rom_pkg::mem_addr_t  cpu_rd_addr, gfx_rd_addr, pcm_rd_addr;
	logic                     cpu_rd_done, gfx_rd_done, pcm_rd_done;
	game_rom_pkg::mem_word_t  rd_data;
	logic                     psel, penable, pwrite, pready;
	game_rom_pkg::mem_addr_t  paddr;
	game_rom_pkg::mem_word_t  pwdata, prdata;
	game_rom_pkg::byte_strb_t pstrb;

	rom_loader u_loader (
		.CLK(CLK), .rst_n(rst_n), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .downloading(downloading), .dwnld_busy(dwnld_busy),
		.game(game), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.wr_strb(wr_strb), .wr_done(wr_done)
	);

	rom_slot #(.DW(16)) u_cpu (
		.CLK(CLK), .rst_n(rst_n), .downloading(downloading), .cs(cpu_cs), .addr(cpu_addr),
		.ok(cpu_ok), .dout(cpu_dout), .rd_req(cpu_rd_req), .rd_addr(cpu_rd_addr),
		.rd_done(cpu_rd_done), .rd_data(rd_data)
	);

	rom_slot #(.DW(32)) u_gfx (
		.CLK(CLK), .rst_n(rst_n), .downloading(downloading), .cs(gfx_cs), .addr(gfx_addr),
		.ok(gfx_ok), .dout(gfx_dout), .rd_req(gfx_rd_req), .rd_addr(gfx_rd_addr),
		.rd_done(gfx_rd_done), .rd_data(rd_data)
	);

	rom_slot #(.DW(8)) u_pcm (
		.CLK(CLK), .rst_n(rst_n), .downloading(downloading), .cs(pcm_cs), .addr(pcm_addr),
		.ok(pcm_ok), .dout(pcm_dout), .rd_req(pcm_rd_req), .rd_addr(pcm_rd_addr),
		.rd_done(pcm_rd_done), .rd_data(rd_data)
	);

	rom_arbiter u_arb (
		.CLK(CLK), .rst_n(rst_n),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_done(wr_done),
		.cpu_rd_req(cpu_rd_req), .cpu_rd_addr(cpu_rd_addr), .cpu_rd_done(cpu_rd_done),
		.gfx_rd_req(gfx_rd_req), .gfx_rd_addr(gfx_rd_addr), .gfx_rd_done(gfx_rd_done),
		.pcm_rd_req(pcm_rd_req), .pcm_rd_addr(pcm_rd_addr), .pcm_rd_done(pcm_rd_done),
		.rd_data(rd_data),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
	);

	rom_store u_store (
		.CLK(CLK), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
	);

endmodule

// File: verification/game_rom_chk.sv
// ####################
// bound into game_rom_top, watches its internal APB and done wires
// ####################
`timescale 1ns/1ps

module game_rom_chk (
	input logic                     CLK,
	input logic                     rst_n,
	input logic                     psel,
	input logic                     penable,
	input logic                     pwrite,
	input logic                     pready,
	input game_rom_pkg::mem_addr_t  paddr,
	input game_rom_pkg::mem_word_t  pwdata,
	input game_rom_pkg::byte_strb_t pstrb,
	input logic                     wr_done,
	input logic                     cpu_rd_done,
	input logic                     gfx_rd_done,
	input logic                     pcm_rd_done,
	input logic                     ioctl_wr
);
	// setup and waiting access cycles keep the transfer steady
	apb_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		psel && !(penable && pready) |=> psel && penable && $stable(paddr) &&
			$stable(pwrite) && $stable(pstrb) && (!pwrite || $stable(pwdata)))
		else $error("APB transfer changed before pready");

	done_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0({wr_done, cpu_rd_done, gfx_rd_done, pcm_rd_done}))
		else $error("more than one done pulse");

	// host leaves 5 idle cycles between bytes
	host_pacing: assert property (@(posedge CLK) disable iff (!rst_n)
		ioctl_wr |-> !$past(ioctl_wr, 1) && !$past(ioctl_wr, 2) && !$past(ioctl_wr, 3) &&
			!$past(ioctl_wr, 4) && !$past(ioctl_wr, 5))
		else $error("download bytes too close together");

	reset_idle: assert property (@(posedge CLK) !rst_n |-> !psel)
		else $error("psel high during reset");

endmodule

bind game_rom_top game_rom_chk u_chk (
	.CLK(CLK), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
	.pready(pready), .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
	.wr_done(wr_done), .cpu_rd_done(cpu_rd_done), .gfx_rd_done(gfx_rd_done),
	.pcm_rd_done(pcm_rd_done), .ioctl_wr(ioctl_wr)
);

// File: verification/game_rom_tb.sv
// ####################
// downloads two random images with game 0 and a non zero game
// reads back on all three ports through one compare process
// ####################
`timescale 1ns/1ps
`include "game_rom_params.svh"

module game_rom_tb;

	localparam int TIMEOUT  = 50;   // cycles per wait
	localparam int PORT_CPU = 0;
	localparam int PORT_GFX = 1;
	localparam int PORT_PCM = 2;

	logic                   CLK;
	logic                   rst_n;
	logic                   ioctl_wr;
	game_rom_pkg::dl_addr_t ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic                   downloading;
	logic                   dwnld_busy;
	game_rom_pkg::game_id_t game;
	logic                   cpu_cs, gfx_cs, pcm_cs;
	logic [`GR_MEM_AW-1:0]  cpu_addr;
	logic [`GR_MEM_AW-2:0]  gfx_addr;
	logic [`GR_MEM_AW:0]    pcm_addr;
	logic                   cpu_ok, gfx_ok, pcm_ok;
	logic [15:0]            cpu_dout;
	logic [31:0]            gfx_dout;
	logic [7:0]             pcm_dout;

	logic [7:0]  img [0:(1 << `GR_DL_AW) - 1];  // download stream
	integer      seed;
	int          n_pass;
	int          n_fail;
	int          last_lat;  // cycles from cs to ok of the latest read
	string       name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];

	game_rom_top dut_i (.*);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	// expected data taken straight from the download stream
	function automatic logic [31:0] ref_read(input int port, input logic [7:0] g, input int a);
		int tile_base;
		int pcm_base;
		tile_base = 1 + `GR_CPU_LEN;
		pcm_base  = tile_base + ((g == 8'd0) ? `GR_TILE_LEN_DEF : `GR_TILE_LEN_ALT);
		case (port)
			PORT_CPU: ref_read = {16'h0000, img[1 + 2 * a], img[2 + 2 * a]};
			PORT_GFX: ref_read = {img[tile_base + 4 * a], img[tile_base + 4 * a + 1],
				img[tile_base + 4 * a + 2], img[tile_base + 4 * a + 3]};
			default:  ref_read = {24'h000000, img[pcm_base + a]};
		endcase
	endfunction

	task automatic queue_check(input string name, input logic [31:0] e, input logic [31:0] g);
		name_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(g);
	endtask

	task automatic make_image(input logic [7:0] g);
		logic [31:0] r;
		img[0] = g;
		for (int i = 1; i < (1 << `GR_DL_AW); i++) begin
			r = $random(seed);
			img[i] = r[7:0];
		end
	endtask

	task automatic download(input int len);
		int t;
		@(negedge CLK);
		downloading = 1'b1;
		repeat (2) @(negedge CLK);
		if (!dwnld_busy) begin
			$display("dwnld_busy stayed low while downloading");
			n_fail++;
		end
		for (int i = 0; i < len; i++) begin
			ioctl_wr   = 1'b1;
			ioctl_addr = game_rom_pkg::dl_addr_t'(i);
			ioctl_dout = img[i];
			@(negedge CLK);
			ioctl_wr = 1'b0;
			repeat (5) @(negedge CLK);  // 6 cycles per byte
		end
		downloading = 1'b0;
		t = 0;
		while (dwnld_busy && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (dwnld_busy) begin
			$display("download did not finish, dwnld_busy still high");
			n_fail++;
		end
	endtask

	task automatic drive_cs(input int port, input logic v, input int a);
		case (port)
			PORT_CPU: begin
				cpu_cs   = v;
				cpu_addr = a[`GR_MEM_AW-1:0];
			end
			PORT_GFX: begin
				gfx_cs   = v;
				gfx_addr = a[`GR_MEM_AW-2:0];
			end
			default: begin
				pcm_cs   = v;
				pcm_addr = a[`GR_MEM_AW:0];
			end
		endcase
	endtask

	task automatic sample_port(input int port, output logic okv, output logic [31:0] got);
		case (port)
			PORT_CPU: begin
				okv = cpu_ok;
				got = {16'h0000, cpu_dout};
			end
			PORT_GFX: begin
				okv = gfx_ok;
				got = gfx_dout;
			end
			default: begin
				okv = pcm_ok;
				got = {24'h000000, pcm_dout};
			end
		endcase
	endtask

	// hold cs until ok and then for hold more cycles
	task automatic read_port(input int port, input int a, input logic [7:0] g,
		input int hold, input string name);
		logic [31:0] got;
		logic        okv;
		int          t;
		@(negedge CLK);
		drive_cs(port, 1'b1, a);
		t   = 0;
		okv = 1'b0;
		while (!okv && t < TIMEOUT) begin
			@(negedge CLK);
			sample_port(port, okv, got);
			t++;
		end
		last_lat = t;
		if (!okv) begin
			$display("%s: ok never came within %0d cycles", name, TIMEOUT);
			n_fail++;
		end else begin
			queue_check(name, ref_read(port, g, a), got);
			for (int h = 0; h < hold; h++) begin
				@(negedge CLK);
				sample_port(port, okv, got);
				if (!okv) begin
					$display("%s: ok dropped while cs and addr were held", name);
					n_fail++;
				end
				queue_check($sformatf("%s_hold%0d", name, h), ref_read(port, g, a), got);
			end
		end
		drive_cs(port, 1'b0, a);
	endtask

	// compare process
	always @(posedge CLK) begin
		string       nm;
		logic [31:0] e;
		logic [31:0] g;
		while (exp_q.size() > 0) begin
			nm = name_q.pop_front();
			e  = exp_q.pop_front();
			g  = act_q.pop_front();
			if (g !== e) begin
				$display("** Error %s: expected %h, actual %h", nm, e, g);
				n_fail++;
			end else begin
				$display("%s passed, %h", nm, g);
				n_pass++;
			end
		end
	end

	initial begin
		int          t;
		int          a;
		logic [31:0] r;
		logic [7:0]  g2;
		seed        = 81230;
		n_pass      = 0;
		n_fail      = 0;
		last_lat    = 0;
		rst_n       = 1'b0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		downloading = 1'b0;
		cpu_cs      = 1'b0;
		gfx_cs      = 1'b0;
		pcm_cs      = 1'b0;
		cpu_addr    = '0;
		gfx_addr    = '0;
		pcm_addr    = '0;
		repeat (2) @(negedge CLK);
		rst_n = 1'b1;

		// game 0 image with the short tile region
		make_image(8'h00);
		download(1 + `GR_CPU_LEN + `GR_TILE_LEN_DEF + `GR_PCM_LEN);
		queue_check("game_id_0", 32'h0, {24'h0, game});
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			read_port(PORT_CPU, int'(r[9:0]), 8'h00, 0, $sformatf("cpu_rd_%0d", i));
		end
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			read_port(PORT_GFX, int'(r[8:0]), 8'h00, 0, $sformatf("gfx_rd_%0d", i));
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			a = int'({r[10:1], 1'b0});
			read_port(PORT_PCM, a, 8'h00, 0, $sformatf("pcm_even_%0d", i));
			read_port(PORT_PCM, a + 1, 8'h00, 0, $sformatf("pcm_odd_%0d", i));
		end
		// second read of the same address hits the cache
		read_port(PORT_CPU, 77, 8'h00, 3, "cpu_repeat_a");
		read_port(PORT_CPU, 77, 8'h00, 3, "cpu_repeat_b");
		if (last_lat != 1) begin
			$display("cpu_repeat_b: cached read took %0d cycles instead of 1", last_lat);
			n_fail++;
		end

		// non zero game moves PCM further up the stream
		r  = $random(seed);
		g2 = r[7:0] | 8'h01;
		make_image(g2);
		download(1 + `GR_CPU_LEN + `GR_TILE_LEN_ALT + `GR_PCM_LEN);
		queue_check("game_id_alt", {24'h0, g2}, {24'h0, game});
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			read_port(PORT_PCM, int'(r[10:0]), g2, 0, $sformatf("pcm_alt_%0d", i));
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			read_port(PORT_GFX, int'({1'b1, r[8:0]}), g2, 0, $sformatf("gfx_alt_%0d", i));
		end

		// all three clients at once
		for (int i = 0; i < 3; i++) begin
			fork
				read_port(PORT_CPU, 100 + i, g2, 1, $sformatf("multi_cpu_%0d", i));
				read_port(PORT_GFX, 600 + i, g2, 1, $sformatf("multi_gfx_%0d", i));
				read_port(PORT_PCM, 301 + i, g2, 1, $sformatf("multi_pcm_%0d", i));
			join
		end

		t = 0;
		while (exp_q.size() > 0 && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (exp_q.size() > 0) begin
			$display("compare queue still holds %0d results", exp_q.size());
			n_fail++;
		end
		$display("checks passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: game_rom.f
+incdir+rtl
rtl/game_rom_pkg.sv
rtl/rom_loader.sv
rtl/rom_slot.sv
rtl/rom_arbiter.sv
rtl/rom_store.sv
rtl/game_rom_top.sv
verification/game_rom_chk.sv
verification/game_rom_tb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = game_rom_tb
FILELIST   = game_rom.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
